/* design/branch_unit.sv */
/*
 * early branch and jump resolution in decode
 * assumes i_pc is at least halfword aligned
 */
`timescale 1ns/1ps
`include "id_macros.svh"

module branch_unit (
	input  logic [`XLEN-1:0] i_rs1_data,
	input  logic [`XLEN-1:0] i_rs2_data,
	input  logic [`XLEN-1:0] i_imm,
	input  logic [`XLEN-1:0] i_pc,
	input  id_pkg::opcode_e  i_opcode,
	input  logic [2:0]       i_funct3,
	output logic             o_take,
	output logic [`XLEN-1:0] o_target
);

	logic             eq;
	logic             lt;   // signed
	logic             ltu;  // unsigned
	logic             cond;
	logic [`XLEN-1:0] jalr_sum;

	assign eq  = (i_rs1_data == i_rs2_data);
	assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
	assign ltu = (i_rs1_data < i_rs2_data);

	always_comb begin
		case (i_funct3)
			id_pkg::BR_BEQ:  cond = eq;
			id_pkg::BR_BNE:  cond = !eq;
			id_pkg::BR_BLT:  cond = lt;
			id_pkg::BR_BGE:  cond = !lt;
			id_pkg::BR_BLTU: cond = ltu;
			id_pkg::BR_BGEU: cond = !ltu;
			default:         cond = 1'b0; // reserved encodings never branch
		endcase
	end

	assign o_take = (i_opcode == id_pkg::OPC_JAL) ||
		(i_opcode == id_pkg::OPC_JALR) ||
		((i_opcode == id_pkg::OPC_BRANCH) && cond);

	assign jalr_sum = i_rs1_data + i_imm;
	// JALR drops bit 0 of the sum, others are pc relative
	assign o_target = (i_opcode == id_pkg::OPC_JALR) ?
		{jalr_sum[`XLEN-1:1], 1'b0} : (i_pc + i_imm);

	// relies on imm_gen zeroing bit 0 of B and J offsets
	always_comb begin
		if (o_take) begin
			a_target_aligned: assert final (o_target[0] == 1'b0)
				else $error("redirect target %h is odd", o_target);
		end
	end

endmodule

/* design/control_unit.sv */
/*
 * ALU control from opcode, funct3 and funct7 bit 5
 * o_valid drops for any opcode outside RV32I base, code is then ADD
 */
`timescale 1ns/1ps

module control_unit (
	input  id_pkg::instr_u    i_instr,
	output id_pkg::alu_ctrl_e o_alu_ctrl,
	output logic              o_valid
);

	logic alt;   // funct7[5], instr bit 30
	logic is_op; // register-register form

	assign alt   = i_instr.r.funct7[5];
	assign is_op = (i_instr.r.opcode == id_pkg::OPC_OP);

	always_comb begin
		o_alu_ctrl = id_pkg::ALU_ADD;
		o_valid    = 1'b1;
		case (i_instr.r.opcode)
			id_pkg::OPC_OP,
			id_pkg::OPC_OP_IMM: begin
				case (i_instr.r.funct3)
					3'b000: begin
						// ADDI has no subtract form
						o_alu_ctrl = (alt && is_op) ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
					end
					3'b001: o_alu_ctrl = id_pkg::ALU_SLL;
					3'b010: o_alu_ctrl = id_pkg::ALU_SLT;
					3'b011: o_alu_ctrl = id_pkg::ALU_SLTU;
					3'b100: o_alu_ctrl = id_pkg::ALU_XOR;
					3'b101: begin
						o_alu_ctrl = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL; // same for SRAI
					end
					3'b110: o_alu_ctrl = id_pkg::ALU_OR;
					default: o_alu_ctrl = id_pkg::ALU_AND;
				endcase
			end
			id_pkg::OPC_LOAD,
			id_pkg::OPC_STORE,
			id_pkg::OPC_LUI,
			id_pkg::OPC_AUIPC,
			id_pkg::OPC_JAL,
			id_pkg::OPC_JALR: begin
				o_alu_ctrl = id_pkg::ALU_ADD; // address or link arithmetic
			end
			id_pkg::OPC_BRANCH: begin
				o_alu_ctrl = id_pkg::ALU_SUB; // compare in execute
			end
			default: begin
				o_valid = 1'b0; // top swaps in the NOP
			end
		endcase
	end

endmodule

/* design/id_pkg.sv */
/*
 * RV32I decode types shared by the decode stage blocks
 * only the opcodes of the base integer set are listed
 */
package id_pkg;

	// major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	// alu codes follow {funct7[5], funct3}
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SUB  = 4'b1000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_SRA  = 4'b1101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111
	} alu_ctrl_e;

	// funct3 of the BRANCH opcode, 010 and 011 are reserved
	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} br_f3_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;   // imm[11:0], shamt sits in the low bits
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi; // imm[11:5]
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo; // imm[4:0]
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm31_12;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	// one instruction word seen through every format
	typedef union packed {
		logic [31:0] raw;
		r_fmt_t      r;
		i_fmt_t      i;
		s_fmt_t      s;
		b_fmt_t      b;
		u_fmt_t      u;
		j_fmt_t      j;
	} instr_u;

endpackage

/* design/id_stage.sv */
/*
 * RV32I decode stage with a one-cycle ID/EX register
 * o_flush and o_branch_pc are combinational, fetch drops its next word
 * unknown opcodes pass on as ADDI x0,x0,0
 */
`timescale 1ns/1ps
`include "id_macros.svh"

module id_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [`XLEN-1:0]   i_instr,     // fetched word
	input  logic [`XLEN-1:0]   i_pc,        // pc of i_instr
	input  logic               i_ce,        // fetch has a word for us
	input  logic               i_stall,     // execute holds the pipe
	input  logic               i_wr,        // write-back strobe
	input  logic [`REG_AW-1:0] i_wr_addr,
	input  logic [`XLEN-1:0]   i_wr_data,
	output logic [`XLEN-1:0]   o_rs1_data,
	output logic [`XLEN-1:0]   o_rs2_data,
	output logic [`XLEN-1:0]   o_imm_data,
	output logic [6:0]         o_opcode,
	output logic [2:0]         o_funct3,
	output logic [`REG_AW-1:0] o_rd,
	output logic [3:0]         o_alu_ctrl,
	output logic [`XLEN-1:0]   o_pc,
	output logic               o_ce,        // ID/EX holds a valid instruction
	output logic               o_flush,     // redirect fetch this cycle
	output logic [`XLEN-1:0]   o_branch_pc
);

	id_pkg::instr_u    raw_instr; // word as fetched
	id_pkg::instr_u    d_instr;   // word after NOP substitution
	id_pkg::alu_ctrl_e alu_ctrl;
	logic              instr_ok;
	logic [`XLEN-1:0]  imm;
	logic              take;
	logic [`XLEN-1:0]  target;
	logic              accept;

	rf_read_if u_rf_if ();

	assign raw_instr.raw = i_instr;
	assign accept        = i_ce && !i_stall;

	// validity comes from the raw word, ALU code of a bad word is already ADD
	control_unit u_ctrl (
		.i_instr    (raw_instr),
		.o_alu_ctrl (alu_ctrl),
		.o_valid    (instr_ok)
	);

	assign d_instr.raw = instr_ok ? i_instr : `NOP_INSTR;

	// register reads, U and J formats have no sources
	assign u_rf_if.rs1_addr = d_instr.r.rs1;
	assign u_rf_if.rs2_addr = d_instr.r.rs2;
	assign u_rf_if.re = !((d_instr.r.opcode == id_pkg::OPC_LUI) ||
		(d_instr.r.opcode == id_pkg::OPC_AUIPC) ||
		(d_instr.r.opcode == id_pkg::OPC_JAL));

	reg_file u_rf (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_wr      (i_wr),
		.i_wr_addr (i_wr_addr),
		.i_wr_data (i_wr_data),
		.rd        (u_rf_if)
	);

	imm_gen u_imm (
		.i_instr (d_instr),
		.o_imm   (imm)
	);

	branch_unit u_br (
		.i_rs1_data (u_rf_if.rs1_data),
		.i_rs2_data (u_rf_if.rs2_data),
		.i_imm      (imm),
		.i_pc       (i_pc),
		.i_opcode   (d_instr.r.opcode),
		.i_funct3   (d_instr.r.funct3),
		.o_take     (take),
		.o_target   (target)
	);

	// redirect only for an instruction that really enters the pipe
	assign o_flush     = accept && take;
	assign o_branch_pc = target;

	// ID/EX register, loads on accept and holds otherwise
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_rs1_data <= '0;
			o_rs2_data <= '0;
			o_imm_data <= '0;
			o_opcode   <= '0;
			o_funct3   <= '0;
			o_rd       <= '0;
			o_alu_ctrl <= '0;
			o_pc       <= '0;
			o_ce       <= 1'b0;
		end else begin
			o_ce <= accept; // bubble on stall or empty fetch
			if (accept) begin
				o_rs1_data <= u_rf_if.rs1_data;
				o_rs2_data <= u_rf_if.rs2_data;
				o_imm_data <= imm;
				o_opcode   <= d_instr.r.opcode;
				o_funct3   <= d_instr.r.funct3;
				o_rd       <= d_instr.r.rd;
				o_alu_ctrl <= alu_ctrl;
				o_pc       <= i_pc;
			end
		end
	end

	// a redirecting instruction still reaches execute as a jump or branch
	a_flush_reaches_ex: assert property (
		@(posedge clk) disable iff (!rst_n)
		o_flush |=> (o_ce && (o_opcode == id_pkg::OPC_JAL ||
			o_opcode == id_pkg::OPC_JALR || o_opcode == id_pkg::OPC_BRANCH))
	) else $error("redirecting instruction did not reach execute");

endmodule

/* design/imm_gen.sv */
/*
 * sign-extended immediate for the I, S, B, U and J formats
 * other opcodes give zero, shift forms keep the raw I field
 */
`timescale 1ns/1ps
`include "id_macros.svh"

module imm_gen (
	input  id_pkg::instr_u    i_instr,
	output logic [`XLEN-1:0]  o_imm
);

	always_comb begin
		case (i_instr.r.opcode)
			id_pkg::OPC_LOAD,
			id_pkg::OPC_OP_IMM,
			id_pkg::OPC_JALR: begin
				// shamt and funct7 bits ride along, bit 11 is zero there
				o_imm = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
			end
			id_pkg::OPC_STORE: begin
				o_imm = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
			end
			id_pkg::OPC_BRANCH: begin
				o_imm = {{19{i_instr.b.imm12}},
					i_instr.b.imm12,
					i_instr.b.imm11,
					i_instr.b.imm10_5,
					i_instr.b.imm4_1,
					1'b0}; // halfword offset
			end
			id_pkg::OPC_LUI,
			id_pkg::OPC_AUIPC: begin
				o_imm = {i_instr.u.imm31_12, 12'b0};
			end
			id_pkg::OPC_JAL: begin
				o_imm = {{11{i_instr.j.imm20}},
					i_instr.j.imm20,
					i_instr.j.imm19_12,
					i_instr.j.imm11,
					i_instr.j.imm10_1,
					1'b0};
			end
			default: begin
				o_imm = '0; // R format and unknown
			end
		endcase
	end

endmodule

/* design/reg_file.sv */
/*
 * 32x32 register file, x0 reads zero and ignores writes
 * write lands at the rising edge, same-cycle reads see the write data
 */
`timescale 1ns/1ps
`include "id_macros.svh"

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_wr,      // write strobe from write-back
	input  logic [`REG_AW-1:0] i_wr_addr,
	input  logic [`XLEN-1:0]   i_wr_data,
	rf_read_if.regfile         rd
);

	logic [`XLEN-1:0] regs [1:`NREGS-1]; // x0 has no storage
	logic             wr_en;
	logic             hit1;
	logic             hit2;

	assign wr_en = i_wr && (i_wr_addr != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 1; k < `NREGS; k++) begin
				regs[k] <= '0;
			end
		end else if (wr_en) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// bypass when write-back targets the register being read
	assign hit1 = wr_en && (i_wr_addr == rd.rs1_addr);
	assign hit2 = wr_en && (i_wr_addr == rd.rs2_addr);

	always_comb begin
		rd.rs1_data = '0;
		if (rd.re && rd.rs1_addr != '0) begin
			rd.rs1_data = hit1 ? i_wr_data : regs[rd.rs1_addr];
		end
	end

	always_comb begin
		rd.rs2_data = '0;
		if (rd.re && rd.rs2_addr != '0) begin
			rd.rs2_data = hit2 ? i_wr_data : regs[rd.rs2_addr];
		end
	end

	// a bypassed read must match what the register holds once the write lands
	a_bypass_commits: assert property (
		@(posedge clk) disable iff (!rst_n)
		(rd.re && hit1) |=> (regs[$past(rd.rs1_addr)] == $past(rd.rs1_data))
	) else $error("bypassed rs1 value differs from the committed register");

endmodule

/* design/rf_read_if.sv */
/*
 * two combinational register read ports, no handshake
 * data reads zero while re is low
 */
`timescale 1ns/1ps
`include "id_macros.svh"

interface rf_read_if;
	logic [`REG_AW-1:0] rs1_addr;
	logic [`REG_AW-1:0] rs2_addr;
	logic               re;       // low for LUI, AUIPC, JAL
	logic [`XLEN-1:0]   rs1_data;
	logic [`XLEN-1:0]   rs2_data;

	modport decoder (
		output rs1_addr, rs2_addr, re,
		input  rs1_data, rs2_data
	);

	modport regfile (
		input  rs1_addr, rs2_addr, re,
		output rs1_data, rs2_data
	);
endinterface

/* include/id_macros.svh */
/*
 * widths and constants of the RV32I decode stage
 * REG_AW must stay log2 of NREGS
 */
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// data path and address width
`define XLEN 32

// architectural registers, x0 included
`define NREGS 32

// register index width
`define REG_AW 5

// ADDI x0,x0,0 replaces any unknown opcode
`define NOP_INSTR 32'h0000_0013

`endif

/* run.sh */
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator, log to sim.log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_id_stage -f src.f -o sim_id \
	&& ./obj_dir/sim_id 2>&1 | tee sim.log \
	|| { echo "build or simulation error"; exit 1; }
grep -q "Verification failed" sim.log && exit 1
exit 0

/* src.f */
+incdir+include
design/id_pkg.sv
design/rf_read_if.sv
design/reg_file.sv
design/imm_gen.sv
design/control_unit.sv
design/branch_unit.sv
design/id_stage.sv
test/tb_id_stage.sv

/* test/tb_id_stage.sv */
/*
 * random testbench of the decode stage, xorshift stimulus from a fixed seed
 * registered outputs sampled at the falling edge, redirect a quarter period later
 */
`timescale 1ns/1ps

module tb_id_stage;

	localparam int HALF    = 20;   // 40 ns period
	localparam int NCYCLES = 2000;
	localparam int CE_WAIT = 8;    // cycles allowed for the first o_ce

	// one ID/EX slot as the model predicts it
	typedef struct packed {
		logic [31:0] rs1;
		logic [31:0] rs2;
		logic [31:0] imm;
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [3:0]  alu;
		logic [31:0] pc;
	} slot_t;

	logic        clk;
	logic        rst_n;
	logic [31:0] i_instr;
	logic [31:0] i_pc;
	logic        i_ce;
	logic        i_stall;
	logic        i_wr;
	logic [4:0]  i_wr_addr;
	logic [31:0] i_wr_data;
	logic [31:0] o_rs1_data;
	logic [31:0] o_rs2_data;
	logic [31:0] o_imm_data;
	logic [6:0]  o_opcode;
	logic [2:0]  o_funct3;
	logic [4:0]  o_rd;
	logic [3:0]  o_alu_ctrl;
	logic [31:0] o_pc;
	logic        o_ce;
	logic        o_flush;
	logic [31:0] o_branch_pc;

	logic [31:0] shadow [0:31]; // x0 entry never written
	logic [31:0] rng;
	slot_t       exp_q;         // expected ID/EX contents
	slot_t       exp_n;         // decode of the word driven this cycle
	logic        exp_ce;
	logic        exp_flush;
	logic [31:0] exp_target;
	int          checks;
	int          val_errs;
	int          timeouts;
	int          cyc;
	logic        seen;
	int          lat;

	id_stage u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #HALF clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	task automatic compare_val(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			val_errs++;
			$display("** Error: %s = %h, expected %h at cycle %0d", name, got, want, cyc);
		end
	endtask

	// register read as decode sees it, write-back of this cycle wins
	function automatic logic [31:0] shadow_read(input logic [4:0] a);
		if (a == 5'd0) begin
			return 32'd0;
		end
		if (i_wr && i_wr_addr == a) begin
			return i_wr_data;
		end
		return shadow[a];
	endfunction

	task automatic decode_model();
		logic [31:0] w;
		logic [6:0]  op;
		logic        legal;
		logic        re;
		logic        cond;
		w = i_instr;
		case (w[6:0])
			id_pkg::OPC_LUI, id_pkg::OPC_AUIPC, id_pkg::OPC_JAL, id_pkg::OPC_JALR,
			id_pkg::OPC_BRANCH, id_pkg::OPC_LOAD, id_pkg::OPC_STORE,
			id_pkg::OPC_OP_IMM, id_pkg::OPC_OP: legal = 1'b1;
			default: legal = 1'b0;
		endcase
		if (!legal) begin
			w = 32'h0000_0013; // ADDI x0,x0,0
		end
		op = w[6:0];
		re = !(op == id_pkg::OPC_LUI || op == id_pkg::OPC_AUIPC || op == id_pkg::OPC_JAL);
		exp_n.rs1 = re ? shadow_read(w[19:15]) : 32'd0;
		exp_n.rs2 = re ? shadow_read(w[24:20]) : 32'd0;
		exp_n.opc = op;
		exp_n.f3  = w[14:12];
		exp_n.rd  = w[11:7];
		exp_n.pc  = i_pc;
		case (op)
			id_pkg::OPC_LOAD, id_pkg::OPC_OP_IMM, id_pkg::OPC_JALR:
				exp_n.imm = {{20{w[31]}}, w[31:20]};
			id_pkg::OPC_STORE:
				exp_n.imm = {{20{w[31]}}, w[31:25], w[11:7]};
			id_pkg::OPC_BRANCH:
				exp_n.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			id_pkg::OPC_LUI, id_pkg::OPC_AUIPC:
				exp_n.imm = {w[31:12], 12'd0};
			id_pkg::OPC_JAL:
				exp_n.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default:
				exp_n.imm = 32'd0; // R format
		endcase
		exp_n.alu = (op == id_pkg::OPC_BRANCH) ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
		if (op == id_pkg::OPC_OP || op == id_pkg::OPC_OP_IMM) begin
			case (w[14:12])
				3'b000: exp_n.alu = (op == id_pkg::OPC_OP && w[30]) ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
				3'b001: exp_n.alu = id_pkg::ALU_SLL;
				3'b010: exp_n.alu = id_pkg::ALU_SLT;
				3'b011: exp_n.alu = id_pkg::ALU_SLTU;
				3'b100: exp_n.alu = id_pkg::ALU_XOR;
				3'b101: exp_n.alu = w[30] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
				3'b110: exp_n.alu = id_pkg::ALU_OR;
				default: exp_n.alu = id_pkg::ALU_AND;
			endcase
		end
		case (w[14:12])
			3'b000: cond = (exp_n.rs1 == exp_n.rs2);
			3'b001: cond = (exp_n.rs1 != exp_n.rs2);
			3'b100: cond = ($signed(exp_n.rs1) < $signed(exp_n.rs2));
			3'b101: cond = ($signed(exp_n.rs1) >= $signed(exp_n.rs2));
			3'b110: cond = (exp_n.rs1 < exp_n.rs2);
			3'b111: cond = (exp_n.rs1 >= exp_n.rs2);
			default: cond = 1'b0; // reserved funct3
		endcase
		exp_flush = i_ce && !i_stall && (op == id_pkg::OPC_JAL || op == id_pkg::OPC_JALR ||
			(op == id_pkg::OPC_BRANCH && cond));
		exp_target = (op == id_pkg::OPC_JALR) ? ((exp_n.rs1 + exp_n.imm) & ~32'd1) :
			(i_pc + exp_n.imm);
	endtask

	task automatic pick_stimulus();
		logic [31:0] r;
		logic [31:0] r2;
		logic [31:0] w;
		logic [6:0]  op;
		r  = next_rand();
		r2 = next_rand();
		if (r[3:0] == 4'd0) begin
			case (r[5:4]) // opcodes outside RV32I base
				2'd0: op = 7'b0001111; // FENCE
				2'd1: op = 7'b1110011; // SYSTEM
				2'd2: op = 7'b0000000;
				default: op = 7'b1111111;
			endcase
		end else begin
			case (int'(r[11:4]) % 9)
				0: op = id_pkg::OPC_LUI;
				1: op = id_pkg::OPC_AUIPC;
				2: op = id_pkg::OPC_JAL;
				3: op = id_pkg::OPC_JALR;
				4: op = id_pkg::OPC_BRANCH;
				5: op = id_pkg::OPC_LOAD;
				6: op = id_pkg::OPC_STORE;
				7: op = id_pkg::OPC_OP_IMM;
				default: op = id_pkg::OPC_OP;
			endcase
		end
		w = next_rand();
		w[6:0] = op;
		if (op == id_pkg::OPC_OP) begin
			w[31:25] = {1'b0, w[30], 5'd0}; // funct7 of 0x00 or 0x20
		end
		if (r[12]) begin
			w[19:15] = {2'b00, r[15:13]}; // crowd x0..x7 for bypass hits
		end
		if (r[16]) begin
			w[24:20] = {2'b00, r[19:17]};
		end
		i_instr   = w;
		i_ce      = (r[27:20] >= 8'd26);  // low about 10 %
		i_stall   = (r2[7:0] < 8'd26);    // high about 10 %
		i_wr      = r2[8];
		i_wr_addr = r2[9] ? {2'b00, r2[12:10]} : r2[17:13];
		i_wr_data = r2[18] ? {30'd0, r2[20:19]} : next_rand(); // small values make equal operands
		w         = next_rand();
		i_pc      = {w[31:2], 2'b00};
	endtask

	// check the held slot, drive on the falling edge, check redirect, then commit at the rise
	task automatic run_cycle(input logic rnd, input logic [31:0] instr, input logic ce,
		output logic ce_seen);
		@(negedge clk);
		cyc++;
		ce_seen = o_ce;
		compare_val("o_ce", 32'(o_ce), 32'(exp_ce));
		compare_val("o_rs1_data", o_rs1_data, exp_q.rs1);
		compare_val("o_rs2_data", o_rs2_data, exp_q.rs2);
		compare_val("o_imm_data", o_imm_data, exp_q.imm);
		compare_val("o_opcode", 32'(o_opcode), 32'(exp_q.opc));
		compare_val("o_funct3", 32'(o_funct3), 32'(exp_q.f3));
		compare_val("o_rd", 32'(o_rd), 32'(exp_q.rd));
		compare_val("o_alu_ctrl", 32'(o_alu_ctrl), 32'(exp_q.alu));
		compare_val("o_pc", o_pc, exp_q.pc);
		if (rnd) begin
			pick_stimulus();
		end else begin
			i_instr   = instr;
			i_pc      = 32'h0000_1000;
			i_ce      = ce;
			i_stall   = 1'b0;
			i_wr      = 1'b0;
			i_wr_addr = 5'd0;
			i_wr_data = 32'd0;
		end
		decode_model();
		#(HALF / 2);
		compare_val("o_flush", 32'(o_flush), 32'(exp_flush));
		if (exp_flush) begin
			compare_val("o_branch_pc", o_branch_pc, exp_target);
		end
		@(posedge clk);
		if (i_wr && i_wr_addr != 5'd0) begin
			shadow[i_wr_addr] = i_wr_data;
		end
		exp_ce = i_ce && !i_stall;
		if (exp_ce) begin
			exp_q = exp_n; // held otherwise
		end
	endtask

	task automatic wait_for_ce(output int cycles);
		logic s;
		cycles = 0;
		for (int k = 1; k <= CE_WAIT; k++) begin
			run_cycle(1'b0, 32'h0000_0013, 1'b0, s); // idle fetch while waiting
			if (s) begin
				cycles = k;
				break;
			end
		end
		assert (cycles != 0) else begin
			timeouts++;
			$display("timed out after %0d cycles waiting for o_ce to rise", CE_WAIT);
		end
	endtask

	initial begin
		rng        = 32'h63d9_2199;
		rst_n      = 1'b0;
		i_instr    = 32'h0000_0013;
		i_pc       = 32'd0;
		i_ce       = 1'b0;
		i_stall    = 1'b0;
		i_wr       = 1'b0;
		i_wr_addr  = 5'd0;
		i_wr_data  = 32'd0;
		exp_q      = '0;
		exp_n      = '0;
		exp_ce     = 1'b0;
		exp_flush  = 1'b0;
		exp_target = 32'd0;
		checks     = 0;
		val_errs   = 0;
		timeouts   = 0;
		cyc        = 0;
		for (int k = 0; k < 32; k++) begin
			shadow[k] = 32'd0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#(HALF / 2);
		compare_val("o_ce", 32'(o_ce), 32'd0);
		compare_val("o_flush", 32'(o_flush), 32'd0);
		compare_val("o_rs1_data", o_rs1_data, 32'd0);
		// ADDI x1,x0,5 accepted once, o_ce expected one cycle later
		run_cycle(1'b0, 32'h0050_0093, 1'b1, seen);
		wait_for_ce(lat);
		if (lat != 0) begin
			compare_val("o_ce latency", 32'(lat), 32'd1);
		end
		for (int n = 0; n < NCYCLES; n++) begin
			run_cycle(1'b1, 32'd0, 1'b0, seen);
		end
		$display("checks %0d, value errors %0d, timeouts %0d", checks, val_errs, timeouts);
		if (val_errs == 0 && timeouts == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
